/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int opcode_w   = 7;
  localparam int funct3_w   = 3;

  // base opcodes the core acts on, anything else is a no-op
  typedef enum logic [opcode_w-1:0] {
    op_imm = 7'b001_0011,
    auipc  = 7'b001_0111,
    lui    = 7'b011_0111,
    jal    = 7'b110_1111,
    jalr   = 7'b110_0111,
    load   = 7'b000_0011,
    store  = 7'b010_0011,
    system = 7'b111_0011
  } opcode_t;

  // op_imm funct3, only addi is kept
  localparam logic [funct3_w-1:0] f3_addi = 3'b000;

  // load/store width codes
  localparam logic [funct3_w-1:0] f3_byte   = 3'b000;
  localparam logic [funct3_w-1:0] f3_half   = 3'b001;
  localparam logic [funct3_w-1:0] f3_word   = 3'b010;
  localparam logic [funct3_w-1:0] f3_byte_u = 3'b100;
  localparam logic [funct3_w-1:0] f3_half_u = 3'b101;

  // the one system encoding that is decoded
  localparam logic [xlen-1:0] inst_ebreak = 32'h0010_0073;

  // register write-back source
  typedef enum logic [1:0] {
    wb_add  = 2'd0, // adder result
    wb_link = 2'd1, // pc + 4
    wb_load = 2'd2  // extracted load value
  } wb_src_t;

  // first adder operand
  typedef enum logic [1:0] {
    op1_rs1  = 2'd0,
    op1_pc   = 2'd1,
    op1_zero = 2'd2
  } op1_src_t;

endpackage

/* hw/rv_bus_pkg.sv */
package rv_bus_pkg;

  // wishbone classic port, byte granular select
  localparam int adr_w = 32;
  localparam int dat_w = 32;
  localparam int sel_w = dat_w / 8;

  // first fetch address after reset
  localparam logic [31:0] default_reset_pc = 32'h8000_0000;

endpackage

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                              clk,
  input  logic                              wen,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1addr,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2addr,
  input  logic [rv_isa_pkg::xlen-1:0]       wdata,
  output logic [rv_isa_pkg::xlen-1:0]       rs1data,
  output logic [rv_isa_pkg::xlen-1:0]       rs2data
);

  logic [rv_isa_pkg::xlen-1:0] regs [2**rv_isa_pkg::reg_addr_w];

  always_ff @(posedge clk) begin
    if (wen && waddr != '0) regs[waddr] <= wdata; // x0 never written
  end

  // x0 reads as zero regardless of array contents
  assign rs1data = (rs1addr == '0) ? '0 : regs[rs1addr];
  assign rs2data = (rs2addr == '0) ? '0 : regs[rs2addr];

endmodule

/* hw/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  logic [rv_isa_pkg::xlen-1:0]       inst,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rd,
  output logic [rv_isa_pkg::xlen-1:0]       imm,
  output rv_isa_pkg::op1_src_t              op1_src,
  output rv_isa_pkg::wb_src_t               wb_src,
  output logic                              reg_write,
  output logic                              mem_read,
  output logic                              mem_write,
  output logic                              is_jump,
  output logic                              is_ebreak,
  output logic [rv_isa_pkg::funct3_w-1:0]   funct3
);

  rv_isa_pkg::opcode_t         opcode;
  logic [rv_isa_pkg::xlen-1:0] imm_i;
  logic [rv_isa_pkg::xlen-1:0] imm_s;
  logic [rv_isa_pkg::xlen-1:0] imm_u;
  logic [rv_isa_pkg::xlen-1:0] imm_j;
  logic                        load_f3_ok;
  logic                        store_f3_ok;

  assign opcode = rv_isa_pkg::opcode_t'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // reserved width codes fall through as no-ops
  assign load_f3_ok = (funct3 == rv_isa_pkg::f3_byte)   ||
                      (funct3 == rv_isa_pkg::f3_half)   ||
                      (funct3 == rv_isa_pkg::f3_word)   ||
                      (funct3 == rv_isa_pkg::f3_byte_u) ||
                      (funct3 == rv_isa_pkg::f3_half_u);
  assign store_f3_ok = (funct3 == rv_isa_pkg::f3_byte) ||
                       (funct3 == rv_isa_pkg::f3_half) ||
                       (funct3 == rv_isa_pkg::f3_word);

  // ecall and csr ops share the opcode but do nothing here
  assign is_ebreak = (inst == rv_isa_pkg::inst_ebreak);

  always_comb begin
    imm       = '0;
    op1_src   = rv_isa_pkg::op1_zero;
    wb_src    = rv_isa_pkg::wb_add;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_jump   = 1'b0;
    case (opcode)
      rv_isa_pkg::op_imm: begin
        if (funct3 == rv_isa_pkg::f3_addi) begin
          imm       = imm_i;
          op1_src   = rv_isa_pkg::op1_rs1;
          reg_write = 1'b1;
        end
      end
      rv_isa_pkg::lui: begin
        imm       = imm_u; // added to zero
        reg_write = 1'b1;
      end
      rv_isa_pkg::auipc: begin
        imm       = imm_u;
        op1_src   = rv_isa_pkg::op1_pc;
        reg_write = 1'b1;
      end
      rv_isa_pkg::jal: begin
        imm       = imm_j;
        op1_src   = rv_isa_pkg::op1_pc;
        wb_src    = rv_isa_pkg::wb_link;
        reg_write = 1'b1;
        is_jump   = 1'b1;
      end
      rv_isa_pkg::jalr: begin
        imm       = imm_i;
        op1_src   = rv_isa_pkg::op1_rs1;
        wb_src    = rv_isa_pkg::wb_link;
        reg_write = 1'b1;
        is_jump   = 1'b1;
      end
      rv_isa_pkg::load: begin
        if (load_f3_ok) begin
          imm       = imm_i;
          op1_src   = rv_isa_pkg::op1_rs1;
          wb_src    = rv_isa_pkg::wb_load;
          reg_write = 1'b1;
          mem_read  = 1'b1;
        end
      end
      rv_isa_pkg::store: begin
        if (store_f3_ok) begin
          imm       = imm_s;
          op1_src   = rv_isa_pkg::op1_rs1;
          mem_write = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  logic [rv_isa_pkg::xlen-1:0] pc,
  input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0] imm,
  input  rv_isa_pkg::op1_src_t        op1_src,
  input  rv_isa_pkg::wb_src_t         wb_src,
  input  logic                        is_jump,
  input  logic [rv_isa_pkg::xlen-1:0] load_value,
  output logic [rv_isa_pkg::xlen-1:0] sum,
  output logic [rv_isa_pkg::xlen-1:0] next_pc,
  output logic [rv_isa_pkg::xlen-1:0] wdata
);

  logic [rv_isa_pkg::xlen-1:0] op1;
  logic [rv_isa_pkg::xlen-1:0] link; // pc + 4

  always_comb begin
    case (op1_src)
      rv_isa_pkg::op1_rs1: op1 = rs1_data;
      rv_isa_pkg::op1_pc:  op1 = pc;
      default:             op1 = '0;
    endcase
  end

  // single adder serves addi, lui, auipc, jump targets and addresses
  assign sum  = op1 + imm;
  assign link = pc + 32'd4;

  // jal targets are already even, so clearing bit 0 only matters for jalr
  assign next_pc = is_jump ? {sum[rv_isa_pkg::xlen-1:1], 1'b0} : link;

  always_comb begin
    case (wb_src)
      rv_isa_pkg::wb_link: wdata = link;
      rv_isa_pkg::wb_load: wdata = load_value;
      default:             wdata = sum;
    endcase
  end

endmodule

/* hw/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
  input  logic [rv_isa_pkg::funct3_w-1:0] funct3,
  input  logic [1:0]                      addr_low,
  input  logic [rv_isa_pkg::xlen-1:0]     rs2_data,
  input  logic [rv_bus_pkg::dat_w-1:0]    load_word,
  output logic [rv_bus_pkg::dat_w-1:0]    store_data,
  output logic [rv_bus_pkg::sel_w-1:0]    store_sel,
  output logic                            access_ok,
  output logic [rv_isa_pkg::xlen-1:0]     load_value
);

  logic [7:0]  byte_sel;  // addressed byte of the load word
  logic [15:0] half_sel;  // addressed halfword

  // byte lanes and alignment
  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_byte, rv_isa_pkg::f3_byte_u: begin
        store_data = {4{rs2_data[7:0]}};
        store_sel  = 4'b0001 << addr_low;
        access_ok  = 1'b1;
      end
      rv_isa_pkg::f3_half, rv_isa_pkg::f3_half_u: begin
        store_data = {2{rs2_data[15:0]}};
        store_sel  = addr_low[1] ? 4'b1100 : 4'b0011;
        access_ok  = !addr_low[0];
      end
      rv_isa_pkg::f3_word: begin
        store_data = rs2_data;
        store_sel  = 4'b1111;
        access_ok  = (addr_low == 2'b00);
      end
      default: begin
        store_data = rs2_data;
        store_sel  = '0;
        access_ok  = 1'b0;
      end
    endcase
  end

  assign byte_sel = load_word[8*addr_low +: 8];
  assign half_sel = addr_low[1] ? load_word[31:16] : load_word[15:0];

  // extension uses the extracted part, a refused access reads as zero
  always_comb begin
    if (!access_ok) begin
      load_value = '0;
    end else begin
      case (funct3)
        rv_isa_pkg::f3_byte:   load_value = {{24{byte_sel[7]}}, byte_sel};
        rv_isa_pkg::f3_byte_u: load_value = {24'h00_0000, byte_sel};
        rv_isa_pkg::f3_half:   load_value = {{16{half_sel[15]}}, half_sel};
        rv_isa_pkg::f3_half_u: load_value = {16'h0000, half_sel};
        default:               load_value = load_word;
      endcase
    end
  end

endmodule

/* hw/rv_sequencer.sv */
`timescale 1ns/1ps

module rv_sequencer #(
  parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = rv_bus_pkg::default_reset_pc
) (
  input  logic                         clk,
  input  logic                         rst,
  output logic [rv_isa_pkg::xlen-1:0]  inst,
  output logic [rv_isa_pkg::xlen-1:0]  pc,
  output logic                         reg_write_en,
  output logic                         halted,
  input  logic [rv_isa_pkg::xlen-1:0]  next_pc,
  input  logic [rv_isa_pkg::xlen-1:0]  mem_addr,
  input  logic                         mem_read,
  input  logic                         mem_write,
  input  logic                         reg_write,
  input  logic                         is_ebreak,
  input  logic                         access_ok,
  input  logic [rv_bus_pkg::dat_w-1:0] store_data,
  input  logic [rv_bus_pkg::sel_w-1:0] store_sel,
  output logic [rv_bus_pkg::dat_w-1:0] load_word,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [rv_bus_pkg::adr_w-1:0] wb_adr,
  output logic [rv_bus_pkg::dat_w-1:0] wb_dat_w,
  output logic [rv_bus_pkg::sel_w-1:0] wb_sel,
  input  logic [rv_bus_pkg::dat_w-1:0] wb_dat_r,
  input  logic                         wb_ack
);

  typedef enum logic [2:0] {
    s_idle,  // gap cycle between bus cycles
    s_fetch,
    s_exec,
    s_mem,
    s_halt
  } state_t;

  state_t state;
  logic   mem_go; // load or store that goes out on the bus

  assign mem_go = (mem_read | mem_write) & access_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
      pc    <= reset_pc;
    end else begin
      case (state)
        s_idle: state <= s_fetch;
        s_fetch: begin
          if (wb_ack) state <= s_exec;
        end
        s_exec: begin
          if (is_ebreak) begin
            state <= s_halt; // pc stays on the ebreak
          end else if (mem_go) begin
            state <= s_mem;
          end else begin
            state <= s_idle;
            pc    <= next_pc;
          end
        end
        s_mem: begin
          if (wb_ack) begin
            state <= s_idle;
            pc    <= next_pc;
          end
        end
        s_halt: state <= s_halt; // left only through rst
        default: state <= s_idle;
      endcase
    end
  end

  // instruction word held through execute and the data access
  always_ff @(posedge clk) begin
    if (state == s_fetch && wb_ack) inst <= wb_dat_r;
  end

  // load data is written back in the ack cycle itself
  assign load_word = wb_dat_r;

  // one write per instruction, either at end of execute or at the data ack
  assign reg_write_en = reg_write &&
                        (((state == s_exec) && !mem_go) ||
                         ((state == s_mem) && wb_ack));

  assign halted = (state == s_halt);

  assign wb_cyc   = (state == s_fetch) || (state == s_mem);
  assign wb_stb   = wb_cyc;
  assign wb_we    = (state == s_mem) && mem_write;
  // word address on the bus, byte lanes come from wb_sel
  assign wb_adr   = (state == s_mem) ? {mem_addr[rv_isa_pkg::xlen-1:2], 2'b00} : pc;
  assign wb_sel   = (state == s_mem) ? store_sel : '1; // fetch is a full word
  assign wb_dat_w = store_data;

endmodule

/* hw/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
  parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = rv_bus_pkg::default_reset_pc
) (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [rv_bus_pkg::adr_w-1:0] wb_adr,
  output logic [rv_bus_pkg::dat_w-1:0] wb_dat_w,
  output logic [rv_bus_pkg::sel_w-1:0] wb_sel,
  input  logic [rv_bus_pkg::dat_w-1:0] wb_dat_r,
  input  logic                         wb_ack,
  output logic                         halted,
  output logic [rv_isa_pkg::xlen-1:0]  pc
);

  logic [rv_isa_pkg::xlen-1:0]       inst;
  logic [rv_isa_pkg::xlen-1:0]       next_pc;
  logic [rv_isa_pkg::xlen-1:0]       sum;      // also the data address
  logic [rv_isa_pkg::xlen-1:0]       wdata;
  logic [rv_isa_pkg::xlen-1:0]       imm;
  logic [rv_isa_pkg::xlen-1:0]       rs1_data;
  logic [rv_isa_pkg::xlen-1:0]       rs2_data;
  logic [rv_isa_pkg::xlen-1:0]       load_value;
  logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
  logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
  logic [rv_isa_pkg::reg_addr_w-1:0] rd;
  logic [rv_isa_pkg::funct3_w-1:0]   funct3;
  rv_isa_pkg::op1_src_t              op1_src;
  rv_isa_pkg::wb_src_t               wb_src;
  logic                              reg_write;
  logic                              reg_write_en;
  logic                              mem_read;
  logic                              mem_write;
  logic                              is_jump;
  logic                              is_ebreak;
  logic                              access_ok;
  logic [rv_bus_pkg::dat_w-1:0]      store_data;
  logic [rv_bus_pkg::sel_w-1:0]      store_sel;
  logic [rv_bus_pkg::dat_w-1:0]      load_word;

  rv_sequencer #(
    .reset_pc(reset_pc)
  ) sequencer_i (
    .clk          (clk),
    .rst          (rst),
    .inst         (inst),
    .pc           (pc),
    .reg_write_en (reg_write_en),
    .halted       (halted),
    .next_pc      (next_pc),
    .mem_addr     (sum),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .reg_write    (reg_write),
    .is_ebreak    (is_ebreak),
    .access_ok    (access_ok),
    .store_data   (store_data),
    .store_sel    (store_sel),
    .load_word    (load_word),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_sel       (wb_sel),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack)
  );

  rv_decoder decoder_i (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .op1_src   (op1_src),
    .wb_src    (wb_src),
    .reg_write (reg_write),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .is_jump   (is_jump),
    .is_ebreak (is_ebreak),
    .funct3    (funct3)
  );

  rv_execute execute_i (
    .pc         (pc),
    .rs1_data   (rs1_data),
    .imm        (imm),
    .op1_src    (op1_src),
    .wb_src     (wb_src),
    .is_jump    (is_jump),
    .load_value (load_value),
    .sum        (sum),
    .next_pc    (next_pc),
    .wdata      (wdata)
  );

  rv_regfile regfile_i (
    .clk     (clk),
    .wen     (reg_write_en),
    .waddr   (rd),
    .rs1addr (rs1),
    .rs2addr (rs2),
    .wdata   (wdata),
    .rs1data (rs1_data),
    .rs2data (rs2_data)
  );

  rv_lsu lsu_i (
    .funct3     (funct3),
    .addr_low   (sum[1:0]),
    .rs2_data   (rs2_data),
    .load_word  (load_word),
    .store_data (store_data),
    .store_sel  (store_sel),
    .access_ok  (access_ok),
    .load_value (load_value)
  );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [31:0] wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic [3:0]  wb_sel,
  input  logic [31:0] wb_dat_r,
  input  logic        wb_ack,
  input  logic        halted,
  input  logic [31:0] pc,
  output logic        done,
  output int          fail_total
);

  localparam int ack_timeout = 64;

  logic [31:0] m_regs [32];
  int          kind [32];      // 0 arith, 1 link, 2 load
  logic [31:0] m_pc;
  logic        m_halt;
  logic [31:0] exp_addr;
  logic [3:0]  exp_sel;
  logic [31:0] exp_data;
  logic        exp_go;
  int          pass_cnt [6];
  int          fail_cnt [6];
  string       names [6] = '{"reset", "control flow", "arithmetic", "loads", "stores", "halt"};

  function automatic logic [31:0] rd_reg(input logic [4:0] i);
    return (i == 5'd0) ? 32'h0 : m_regs[i];
  endfunction

  // expected data access of a load or store, from the model registers
  function automatic void ref_access(input logic [31:0] inst);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [31:0] imm;
    logic [1:0]  a;
    int          nbytes;
    op = inst[6:0];
    f3 = inst[14:12];
    exp_go = 1'b0;
    if (op == 7'h03 || op == 7'h23) begin
      imm = (op == 7'h03) ? {{20{inst[31]}}, inst[31:20]}
                          : {{20{inst[31]}}, inst[31:25], inst[11:7]};
      exp_addr = rd_reg(inst[19:15]) + imm;
      a = exp_addr[1:0];
      exp_data = rd_reg(inst[24:20]) << (8 * a);
      case (f3[1:0])
        2'b00:   nbytes = 1;
        2'b01:   nbytes = 2;
        default: nbytes = 4;
      endcase
      // lanes covered by the access, aligned when the offset is a multiple of its size
      for (int b = 0; b < 4; b++) begin
        exp_sel[b] = (b >= int'(a)) && (b < int'(a) + nbytes);
      end
      exp_go = (int'(a) % nbytes) == 0;
      if (op == 7'h23 && f3 > 3'b010) exp_go = 1'b0;
      if (op == 7'h03 && (f3 == 3'b011 || f3 >= 3'b110)) exp_go = 1'b0;
    end
  endfunction

  function automatic void write_reg(input logic [4:0] rd, input logic [31:0] v, input int kd);
    if (rd != 5'd0) begin
      m_regs[rd] = v;
      kind[rd]   = kd;
    end
  endfunction

  // one instruction of the reference model
  function automatic void ref_step(input logic [31:0] inst, input logic [31:0] rdata);
    logic [31:0] imm_i;
    logic [31:0] npc;
    logic [31:0] t;
    logic [31:0] sh;
    logic [2:0]  f3;
    imm_i = {{20{inst[31]}}, inst[31:20]};
    f3  = inst[14:12];
    npc = m_pc + 32'd4;
    case (inst[6:0])
      7'h13: if (f3 == 3'b000) write_reg(inst[11:7], rd_reg(inst[19:15]) + imm_i, 0);
      7'h37: write_reg(inst[11:7], {inst[31:12], 12'h0}, 0);
      7'h17: write_reg(inst[11:7], m_pc + {inst[31:12], 12'h0}, 0);
      7'h6f: begin
        npc = m_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        write_reg(inst[11:7], m_pc + 32'd4, 1);
      end
      7'h67: begin
        t = (rd_reg(inst[19:15]) + imm_i) & ~32'h1;
        write_reg(inst[11:7], m_pc + 32'd4, 1);
        npc = t;
      end
      7'h03: begin
        ref_access(inst);
        sh = rdata >> (8 * exp_addr[1:0]);
        case (f3)
          3'b000: t = {{24{sh[7]}}, sh[7:0]};
          3'b100: t = {24'h0, sh[7:0]};
          3'b001: t = {{16{sh[15]}}, sh[15:0]};
          3'b101: t = {16'h0, sh[15:0]};
          default: t = sh;
        endcase
        if (!exp_go) t = 32'h0; // misaligned reads as zero
        if (f3 != 3'b011 && f3 < 3'b110) write_reg(inst[11:7], t, 2);
      end
      7'h73: if (inst == 32'h0010_0073) begin
        m_halt = 1'b1;
        npc    = m_pc;
      end
      default: ;
    endcase
    m_pc = npc;
  endfunction

  task automatic check_val(input int cat, input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
      fail_cnt[cat]++;
    end else begin
      pass_cnt[cat]++;
    end
  endtask

  task automatic wait_ack(output logic ok);
    ok = 1'b0;
    for (int i = 0; i < ack_timeout && !ok; i++) begin
      @(negedge clk);
      if (wb_cyc && wb_stb && wb_ack) ok = 1'b1;
    end
  endtask

  task automatic report_abort(input int cat, input string what);
    $display("%s at %0t", what, $time);
    fail_cnt[cat]++;
  endtask

  initial begin
    logic        ok;
    logic        first;
    logic [31:0] inst;
    logic [31:0] rdata;
    int          fetch_cat;
    int          cat;
    done       = 1'b0;
    fail_total = 0;
    m_pc       = rv_bus_pkg::default_reset_pc;
    m_halt     = 1'b0;
    first      = 1'b1;
    fetch_cat  = 1;
    ok         = 1'b1;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = 32'h0;
      kind[i]   = 0;
    end
    for (int i = 0; i < 6; i++) begin
      pass_cnt[i] = 0;
      fail_cnt[i] = 0;
    end
    @(negedge clk);
    for (int i = 0; i < ack_timeout && rst; i++) begin
      check_val(0, "wb_cyc", 32'h0, {31'h0, wb_cyc});
      check_val(0, "wb_stb", 32'h0, {31'h0, wb_stb});
      @(negedge clk);
    end
    // first cycle out of reset
    check_val(0, "wb_cyc", 32'h0, {31'h0, wb_cyc});
    check_val(0, "wb_stb", 32'h0, {31'h0, wb_stb});
    while (!m_halt && ok) begin
      wait_ack(ok);
      if (!ok) begin
        report_abort(1, "no ack on instruction fetch");
      end else begin
        check_val(fetch_cat, "wb_adr", m_pc, wb_adr);
        check_val(fetch_cat, "wb_we", 32'h0, {31'h0, wb_we});
        check_val(fetch_cat, "wb_sel", 32'hf, {28'h0, wb_sel});
        check_val(1, "pc", m_pc, pc);
        if (first) check_val(0, "wb_adr", rv_bus_pkg::default_reset_pc, wb_adr);
        first = 1'b0;
        inst  = wb_dat_r;
        rdata = 32'h0;
        fetch_cat = 1;
        ref_access(inst);
        cat = 3;
        if (inst[6:0] == 7'h23) begin
          cat = 4;
          if (inst[14:12] == 3'b010 && exp_go) cat = kind[inst[24:20]] + 2 - 2 * kind[inst[24:20]]
                                                      + (kind[inst[24:20]] == 2 ? 3 : 0);
        end
        if (inst[6:0] == 7'h03 || inst[6:0] == 7'h23) begin
          if (exp_go) begin
            wait_ack(ok);
            if (!ok) begin
              report_abort(cat, "no ack on data access");
            end else begin
              check_val(cat, "wb_adr", {exp_addr[31:2], 2'b00}, wb_adr);
              check_val(cat, "wb_sel", {28'h0, exp_sel}, {28'h0, wb_sel});
              check_val(cat, "wb_we", {31'h0, inst[5]}, {31'h0, wb_we});
              if (inst[5]) begin
                check_val(cat, "wb_dat_w", exp_data & {{8{exp_sel[3]}}, {8{exp_sel[2]}},
                          {8{exp_sel[1]}}, {8{exp_sel[0]}}}, wb_dat_w & {{8{exp_sel[3]}},
                          {8{exp_sel[2]}}, {8{exp_sel[1]}}, {8{exp_sel[0]}}});
              end
              rdata = wb_dat_r;
            end
          end else begin
            fetch_cat = inst[5] ? 4 : 3; // next fetch proves no bus cycle
          end
        end
        ref_step(inst, rdata);
      end
    end
    if (ok) begin
      ok = 1'b0;
      for (int i = 0; i < ack_timeout && !ok; i++) begin
        @(negedge clk);
        ok = halted;
      end
      check_val(5, "halted", 32'h1, {31'h0, ok});
      check_val(5, "pc", m_pc, pc); // pc stays on the ebreak
      for (int i = 0; i < 16; i++) begin
        @(negedge clk);
        check_val(5, "wb_stb", 32'h0, {31'h0, wb_stb});
        check_val(5, "halted", 32'h1, {31'h0, halted});
      end
    end
    for (int i = 0; i < 6; i++) begin
      $display("test %s: %0d checks, %0d errors", names[i], pass_cnt[i] + fail_cnt[i],
               fail_cnt[i]);
      fail_total += fail_cnt[i];
      if (pass_cnt[i] + fail_cnt[i] == 0) begin
        $display("test %s ran no checks", names[i]);
        fail_total++;
      end
    end
    $display("total: %0d passed, %0d failed", pass_cnt.sum(), fail_total);
    done = 1'b1;
  end

endmodule

/* dv/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts (
  input logic        clk,
  input logic        rst,
  input logic        wb_cyc,
  input logic        wb_stb,
  input logic        wb_we,
  input logic [31:0] wb_adr,
  input logic [31:0] wb_dat_w,
  input logic [3:0]  wb_sel,
  input logic        wb_ack,
  input logic        halted
);

  stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else $error("wb_stb high without wb_cyc");

  // request held until the slave acks
  req_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_sel) &&
                             $stable(wb_we) && $stable(wb_dat_w)))
    else $error("wishbone request changed before ack");

  no_stb_halted: assert property (@(posedge clk) disable iff (rst) halted |-> !wb_stb)
    else $error("wb_stb while halted");

endmodule

bind rv_core_top rv_core_asserts asserts_i (
  .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
  .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_ack(wb_ack),
  .halted(halted)
);

/* dv/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam logic [31:0] reset_pc = rv_bus_pkg::default_reset_pc;
  localparam int mem_words = 1024;
  localparam int done_timeout = 20000;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        halted;
  logic [31:0] pc;
  logic        done;
  int          fail_total;

  logic [31:0] mem [mem_words];
  logic [31:0] lcg_state;
  int          wait_left;
  int          prog_idx;
  int          k;
  int          cycles;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[prog_idx] = word;
    prog_idx++;
  endtask

  tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

  rv_core_top #(.reset_pc(reset_pc)) dut_i (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .halted(halted), .pc(pc)
  );

  tb_checker checker_i (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .halted(halted), .pc(pc), .done(done), .fail_total(fail_total)
  );

  // memory image: lcg data everywhere, program from word 0
  initial begin
    wb_ack    = 1'b0;
    wb_dat_r  = '0;
    lcg_state = 32'h1787_e802;
    for (int i = 0; i < mem_words; i++) begin
      lcg_state = lcg_next(lcg_state);
      mem[i] = lcg_state;
    end
    wait_left = 0;
    prog_idx  = 0;
    emit(enc_u(20'h80000, 5'd1, 7'h37));           // x1 = base
    emit(enc_i(32'h200, 5'd1, 3'b000, 5'd2, 7'h13)); // x2 = data region
    emit(enc_i(32'h300, 5'd1, 3'b000, 5'd3, 7'h13)); // x3 = store area
    emit(enc_i(-32'sd5, 5'd0, 3'b000, 5'd4, 7'h13));
    emit(enc_s(32'd0, 5'd4, 5'd3, 3'b010));
    emit(enc_i(32'd7, 5'd4, 3'b000, 5'd0, 7'h13));   // write to x0
    emit(enc_s(32'd4, 5'd0, 5'd3, 3'b010));
    emit(enc_u(20'h12345, 5'd5, 7'h37));
    emit(enc_s(32'd8, 5'd5, 5'd3, 3'b010));
    emit(enc_u(20'h00001, 5'd6, 7'h17));
    emit(enc_s(32'd12, 5'd6, 5'd3, 3'b010));
    emit(enc_j(32'd8, 5'd7));                        // skips the filler
    emit(enc_i(32'd1, 5'd0, 3'b000, 5'd4, 7'h13));
    emit(enc_s(32'd16, 5'd7, 5'd3, 3'b010));
    emit(enc_u(20'h00000, 5'd8, 7'h17));
    emit(enc_i(32'd13, 5'd8, 3'b000, 5'd9, 7'h67));  // odd target
    emit(enc_i(32'd1, 5'd0, 3'b000, 5'd4, 7'h13));
    emit(enc_s(32'd20, 5'd9, 5'd3, 3'b010));
    k = 6;
    for (int off = 0; off < 4; off++) begin
      emit(enc_i(off, 5'd2, 3'b000, 5'd10, 7'h03));
      emit(enc_s(4 * k, 5'd10, 5'd3, 3'b010));
      k++;
      emit(enc_i(off, 5'd2, 3'b100, 5'd10, 7'h03));
      emit(enc_s(4 * k, 5'd10, 5'd3, 3'b010));
      k++;
    end
    for (int off = 0; off < 4; off += 2) begin
      emit(enc_i(off, 5'd2, 3'b001, 5'd10, 7'h03));
      emit(enc_s(4 * k, 5'd10, 5'd3, 3'b010));
      k++;
      emit(enc_i(off, 5'd2, 3'b101, 5'd10, 7'h03));
      emit(enc_s(4 * k, 5'd10, 5'd3, 3'b010));
      k++;
    end
    for (int off = 0; off < 8; off += 4) begin
      emit(enc_i(off, 5'd2, 3'b010, 5'd10, 7'h03));
      emit(enc_s(4 * k, 5'd10, 5'd3, 3'b010));
      k++;
    end
    emit(enc_i(32'd8, 5'd2, 3'b010, 5'd11, 7'h03));
    for (int off = 0; off < 4; off++) emit(enc_s(256 + off, 5'd11, 5'd3, 3'b000));
    emit(enc_s(32'd264, 5'd11, 5'd3, 3'b001));
    emit(enc_s(32'd266, 5'd11, 5'd3, 3'b001));
    emit(enc_s(32'd269, 5'd11, 5'd3, 3'b001));       // misaligned sh
    emit(enc_s(32'd274, 5'd11, 5'd3, 3'b010));       // misaligned sw
    emit(enc_i(32'd1, 5'd2, 3'b001, 5'd10, 7'h03));  // misaligned lh
    emit(enc_s(4 * k, 5'd10, 5'd3, 3'b010));
    emit(32'h0010_0073);                             // ebreak
    emit(enc_i(32'd1, 5'd0, 3'b000, 5'd4, 7'h13));
  end

  // slave side, driven 1 ns after the edge
  always @(posedge clk) begin
    #1;
    if (rst) begin
      wb_ack = 1'b0;
    end else if (wb_ack) begin
      wb_ack    = 1'b0;
      lcg_state = lcg_next(lcg_state);
      wait_left = int'(lcg_state[17:16]);
    end else if (wb_cyc && wb_stb) begin
      if (wait_left == 0) begin
        wb_ack   = 1'b1;
        wb_dat_r = mem[wb_adr[11:2]];
        if (wb_we) begin
          for (int b = 0; b < 4; b++) begin
            if (wb_sel[b]) mem[wb_adr[11:2]][8*b +: 8] = wb_dat_w[8*b +: 8];
          end
        end
      end else begin
        wait_left--;
      end
    end
  end

  initial begin
    cycles = 0;
    while (!done && cycles < done_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout, the checker did not finish");
      $display("Result: FAILED");
    end else if (fail_total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* rv_core_top.f */
hw/rv_isa_pkg.sv
hw/rv_bus_pkg.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/rv_execute.sv
hw/rv_lsu.sv
hw/rv_sequencer.sv
hw/rv_core_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/rv_core_asserts.sv
dv/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_core -f rv_core_top.f \
  -Mdir obj_dir -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation log has no final result"
  exit 1
fi
exit 0
